// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cache_tb -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== sim.f ====
source/cache_pkg.sv
source/cache_ctrl_if.sv
source/cache_fsm.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/write_back_cache.sv
verification/line_memory_model.sv
verification/cache_tb.sv

// ==== source/cache_ctrl_if.sv ====
// controller to tag/data array signals; cache_fsm takes ctrl, the arrays take tags and data
`timescale 1ns/100ps
`default_nettype none

interface cache_ctrl_if;

    logic              hit;           // indexed line valid and tag matches
    logic              victim_dirty;  // indexed line must be written back
    cache_pkg::tag_t   victim_tag;    // tag currently held at the index
    logic              fill_en;       // load line from memory
    logic              store_en;      // merge processor word

    modport ctrl (
        input  hit,
        input  victim_dirty,
        input  victim_tag,
        output fill_en,
        output store_en
    );

    modport tags (
        output hit,
        output victim_dirty,
        output victim_tag,
        input  fill_en,
        input  store_en
    );

    // data side only needs the write strobes
    modport data (
        input fill_en,
        input store_en
    );

endinterface

`default_nettype wire

// ==== source/cache_data_array.sv ====
// line storage of the cache; word read, word merge on write hit and full line refill from memory
`timescale 1ns/100ps
`default_nettype none

module cache_data_array (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cache_pkg::proc_addr_u addr,
    input  wire cache_pkg::word_t      wdata,
    input  wire cache_pkg::line_t      fill_line,
    output cache_pkg::word_t           rdata,
    output cache_pkg::line_t           line,
    cache_ctrl_if.data                 ctl
);

    cache_pkg::line_t                   line_mem [cache_pkg::num_lines];
    cache_pkg::index_t                  idx;
    logic [cache_pkg::offset_width-1:0] sel;

    assign idx = addr.fields.index;
    assign sel = addr.fields.word;

    // --------------------
    // read side
    assign line  = line_mem[idx];       // goes out as write-back data
    assign rdata = line[sel];

    // --------------------
    // write side
    always_ff @(posedge clk) begin
        if (ctl.fill_en) begin
            line_mem[idx] <= fill_line;             // whole line from memory
        end else if (ctl.store_en) begin
            line_mem[idx][sel] <= wdata;            // merge one word
        end
    end

    // a store in a fill cycle would be lost behind the fill
    a_no_store_on_fill: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctl.fill_en && ctl.store_en))
        else $error("cache_data_array: store dropped by a refill in the same cycle");

endmodule

`default_nettype wire

// ==== source/cache_fsm.sv ====
// miss-handling FSM of the cache; steps idle/compare/allocate/writeback and drives stall and memory requests
`timescale 1ns/100ps
`default_nettype none

module cache_fsm (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    proc_read,
    input  wire                                    proc_write,
    input  wire cache_pkg::proc_addr_u             addr,
    output logic                                   proc_stall,
    output logic                                   mem_read,
    output logic                                   mem_write,
    output logic [cache_pkg::line_addr_width-1:0]  mem_addr,
    input  wire                                    mem_ready,
    cache_ctrl_if.ctrl                             ctl
);

    cache_pkg::cache_state_e                state;
    cache_pkg::cache_state_e                state_nxt;
    logic                                   request;
    logic                                   in_compare;
    logic [cache_pkg::line_addr_width-1:0]  victim_addr;
    logic [cache_pkg::line_addr_width-1:0]  fill_addr;

    assign request     = proc_read | proc_write;
    assign in_compare  = (state == cache_pkg::compare);
    assign victim_addr = {ctl.victim_tag, addr.fields.index};       // old line
    assign fill_addr   = {addr.fields.tag, addr.fields.index};      // requested line

    // --------------------
    // processor side and array strobes
    assign proc_stall   = request & ~(in_compare & ctl.hit);
    assign ctl.store_en = in_compare & ctl.hit & proc_write;        // write hit
    assign ctl.fill_en  = (state == cache_pkg::allocate) & mem_ready;

    // --------------------
    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::idle: begin
                if (request) begin
                    state_nxt = cache_pkg::compare;
                end
            end
            cache_pkg::compare: begin
                if (ctl.hit) begin
                    state_nxt = cache_pkg::idle;        // access completes here
                end else if (ctl.victim_dirty) begin
                    state_nxt = cache_pkg::writeback;
                end else begin
                    state_nxt = cache_pkg::allocate;
                end
            end
            cache_pkg::writeback: begin
                if (mem_ready) begin
                    state_nxt = cache_pkg::allocate;
                end
            end
            cache_pkg::allocate: begin
                if (mem_ready) begin
                    state_nxt = cache_pkg::compare;     // retry, now a hit
                end
            end
            default: state_nxt = cache_pkg::idle;
        endcase
    end

    // --------------------
    // state and registered memory request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_pkg::idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            mem_addr  <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                cache_pkg::compare: begin
                    if (!ctl.hit && ctl.victim_dirty) begin
                        mem_write <= 1'b1;
                        mem_addr  <= victim_addr;
                    end else if (!ctl.hit) begin
                        mem_read <= 1'b1;
                        mem_addr <= fill_addr;
                    end
                end
                cache_pkg::writeback: begin
                    if (mem_ready) begin        // old line accepted, fetch the new one
                        mem_write <= 1'b0;
                        mem_read  <= 1'b1;
                        mem_addr  <= fill_addr;
                    end
                end
                cache_pkg::allocate: begin
                    if (mem_ready) begin
                        mem_read <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // protocol checks
    a_mem_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("cache_fsm: mem_read and mem_write high together");

    a_proc_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(proc_read && proc_write))
        else $error("cache_fsm: proc_read and proc_write high together");

    // processor must hold its address until the access completes
    a_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        proc_stall |=> $stable(addr.flat))
        else $error("cache_fsm: proc_addr changed while stalled");

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
// shared geometry, address view, FSM states and line type for the write-back cache; use by scoped name
`default_nettype none

package cache_pkg;

    // --------------------
    // cache geometry
    localparam int word_width      = 32;
    localparam int words_per_line  = 4;
    localparam int line_width      = word_width * words_per_line;  // 128
    localparam int num_lines       = 8;
    localparam int index_width     = 3;
    localparam int offset_width    = 2;
    localparam int addr_width      = 30;                            // word address
    localparam int tag_width       = addr_width - index_width - offset_width;
    localparam int line_addr_width = tag_width + index_width;       // 28

    // --------------------
    // data and address types
    typedef logic [word_width-1:0]  word_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [index_width-1:0] index_t;

    // word 0 sits in the low bits
    typedef word_t [words_per_line-1:0] line_t;

    typedef struct packed {
        tag_t                    tag;    // high bits
        index_t                  index;
        logic [offset_width-1:0] word;   // word select
    } addr_fields_t;

    // processor address, either flat or split into fields
    typedef union packed {
        logic [addr_width-1:0] flat;
        addr_fields_t          fields;
    } proc_addr_u;

    // --------------------
    // controller states
    typedef enum logic [1:0] {
        idle      = 2'd0,
        compare   = 2'd1,
        allocate  = 2'd2,
        writeback = 2'd3
    } cache_state_e;

endpackage

`default_nettype wire

// ==== source/cache_tag_array.sv ====
// valid, dirty and tag store of the cache; gives hit and victim info for the indexed line
`timescale 1ns/100ps
`default_nettype none

module cache_tag_array (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cache_pkg::proc_addr_u addr,
    cache_ctrl_if.tags                 ctl
);

    logic [cache_pkg::num_lines-1:0]  valid;
    logic [cache_pkg::num_lines-1:0]  dirty;
    cache_pkg::tag_t                  tag_mem [cache_pkg::num_lines];
    cache_pkg::index_t                idx;

    assign idx = addr.fields.index;

    // --------------------
    // lookup is combinational from the index
    assign ctl.hit          = valid[idx] & (tag_mem[idx] == addr.fields.tag);
    assign ctl.victim_dirty = valid[idx] & dirty[idx];
    assign ctl.victim_tag   = tag_mem[idx];

    // line state bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;        // all lines invalid
            dirty <= '0;        // and clean
        end else begin
            if (ctl.fill_en) begin
                valid[idx] <= 1'b1;
                dirty[idx] <= 1'b0;     // fresh copy of memory
            end else if (ctl.store_en) begin
                dirty[idx] <= 1'b1;
            end
        end
    end

    // tag written only on refill
    always_ff @(posedge clk) begin
        if (ctl.fill_en) begin
            tag_mem[idx] <= addr.fields.tag;
        end
    end

    // --------------------
    // checks
    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctl.fill_en && ctl.store_en))
        else $error("cache_tag_array: fill and store in the same cycle");

endmodule

`default_nettype wire

// ==== source/write_back_cache.sv ====
// top of the direct-mapped write-back cache; processor word port and memory line port as plain ports
`timescale 1ns/100ps
`default_nettype none

module write_back_cache (
    input  wire                                   clk,
    input  wire                                   rst_n,
    // processor side
    input  wire                                   proc_read,
    input  wire                                   proc_write,
    input  wire [cache_pkg::addr_width-1:0]       proc_addr,
    input  wire cache_pkg::word_t                 proc_wdata,
    output wire cache_pkg::word_t                 proc_rdata,
    output wire                                   proc_stall,
    // memory side
    output wire                                   mem_read,
    output wire                                   mem_write,
    output wire [cache_pkg::line_addr_width-1:0]  mem_addr,
    output wire cache_pkg::line_t                 mem_wdata,
    input  wire cache_pkg::line_t                 mem_rdata,
    input  wire                                   mem_ready
);

    cache_pkg::proc_addr_u  addr_u;

    assign addr_u.flat = proc_addr;     // split into tag/index/word downstream

    cache_ctrl_if ctl_if ();

    // --------------------
    // controller
    cache_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .addr       (addr_u),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .ctl        (ctl_if.ctrl)
    );

    // --------------------
    // arrays
    cache_tag_array u_tags (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr_u),
        .ctl   (ctl_if.tags)
    );

    cache_data_array u_data (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr_u),
        .wdata     (proc_wdata),
        .fill_line (mem_rdata),     // refill source
        .rdata     (proc_rdata),
        .line      (mem_wdata),     // victim line for write-back
        .ctl       (ctl_if.data)
    );

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
// testbench top for the write-back cache; applies the access table and checks data and memory traffic
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int num_tests      = 16;
    localparam int timeout_cycles = (num_tests + 1) * 40;

    logic                                   clk = 1'b0;
    logic                                   rst_n;
    logic                                   proc_read;
    logic                                   proc_write;
    logic [cache_pkg::addr_width-1:0]       proc_addr;
    cache_pkg::word_t                       proc_wdata;
    cache_pkg::word_t                       proc_rdata;
    logic                                   proc_stall;
    logic                                   mem_read;
    logic                                   mem_write;
    logic [cache_pkg::line_addr_width-1:0]  mem_addr;
    cache_pkg::line_t                       mem_wdata;
    cache_pkg::line_t                       mem_rdata;
    logic                                   mem_ready;

    // --------------------
    // access table
    logic                              op_tab      [num_tests];   // 1 = write
    logic [cache_pkg::addr_width-1:0]  addr_tab    [num_tests];
    cache_pkg::word_t                  wdata_tab   [num_tests];
    cache_pkg::word_t                  exp_tab     [num_tests];   // expected read data
    int                                n_rd_tab    [num_tests];   // expected line reads
    int                                n_wr_tab    [num_tests];   // expected write-backs
    logic [cache_pkg::addr_width-1:0]  wb_addr_tab [num_tests];   // word expected in victim
    cache_pkg::word_t                  wb_word_tab [num_tests];
    int                                table_len = 0;

    int                                errors = 0;
    int                                monitor_errors = 0;
    int                                read_count = 0;
    int                                write_count = 0;
    logic                              req_open = 1'b0;
    logic [cache_pkg::line_addr_width-1:0] held_addr;
    logic [cache_pkg::line_addr_width-1:0] wb_addr_seen;
    cache_pkg::line_t                  wb_line_seen;

    write_back_cache DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    line_memory_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [29:0] mk_addr(input logic [24:0] tag, input logic [2:0] index,
                                            input logic [1:0] word);
        return {tag, index, word};
    endfunction

    function automatic cache_pkg::word_t rule_word(input logic [29:0] a);
        return {2'b00, a} ^ 32'h5a5a_0000;
    endfunction

    task automatic add_access(input logic op, input logic [29:0] a, input cache_pkg::word_t wd,
                              input cache_pkg::word_t exp, input int n_rd, input int n_wr);
        op_tab[table_len]      = op;
        addr_tab[table_len]    = a;
        wdata_tab[table_len]   = wd;
        exp_tab[table_len]     = exp;
        n_rd_tab[table_len]    = n_rd;
        n_wr_tab[table_len]    = n_wr;
        wb_addr_tab[table_len] = '0;
        wb_word_tab[table_len] = '0;
        table_len++;
    endtask

    // victim word that the last added access must push out to memory
    task automatic expect_writeback(input logic [29:0] a, input cache_pkg::word_t w);
        wb_addr_tab[table_len-1] = a;
        wb_word_tab[table_len-1] = w;
    endtask

    task automatic build_table;
        logic [29:0] a;
        logic [29:0] b;
        logic [29:0] c;
        logic [29:0] d;
        logic [29:0] e;
        a = mk_addr(25'd5, 3'd2, 2'd0);
        b = mk_addr(25'd9, 3'd2, 2'd0);         // same index as a
        c = mk_addr(25'd7, 3'd4, 2'd2);
        d = mk_addr(25'd3, 3'd4, 2'd0);         // same index as c
        e = mk_addr(25'h1ff_ffff, 3'd7, 2'd3);
        add_access(1'b0, a, '0, rule_word(a), 1, 0);                    // cold miss
        add_access(1'b0, a + 30'd1, '0, rule_word(a + 30'd1), 0, 0);
        add_access(1'b0, a + 30'd2, '0, rule_word(a + 30'd2), 0, 0);
        add_access(1'b0, a + 30'd3, '0, rule_word(a + 30'd3), 0, 0);
        add_access(1'b1, a + 30'd1, 32'hdead_beef, '0, 0, 0);           // write hit
        add_access(1'b0, a + 30'd1, '0, 32'hdead_beef, 0, 0);
        add_access(1'b0, b, '0, rule_word(b), 1, 1);                    // dirty eviction
        expect_writeback(a + 30'd1, 32'hdead_beef);
        add_access(1'b0, a + 30'd1, '0, 32'hdead_beef, 1, 0);           // from memory now
        add_access(1'b0, a + 30'd3, '0, rule_word(a + 30'd3), 0, 0);
        add_access(1'b1, c, 32'h1234_5678, '0, 1, 0);                   // write miss
        add_access(1'b0, c, '0, 32'h1234_5678, 0, 0);
        add_access(1'b1, d, 32'hcafe_f00d, '0, 1, 1);
        expect_writeback(c, 32'h1234_5678);
        add_access(1'b0, d, '0, 32'hcafe_f00d, 0, 0);
        add_access(1'b0, c, '0, 32'h1234_5678, 1, 1);
        expect_writeback(d, 32'hcafe_f00d);
        add_access(1'b0, e, '0, rule_word(e), 1, 0);
        add_access(1'b0, mk_addr(25'd0, 3'd7, 2'd1), '0, rule_word(mk_addr(25'd0, 3'd7, 2'd1)),
                   1, 0);                                               // clean eviction
    endtask

    task automatic run_access(input int i);
        int rd0;
        int wr0;
        int err0;
        rd0  = read_count;
        wr0  = write_count;
        err0 = errors + monitor_errors;
        @(posedge clk);
        proc_read  <= ~op_tab[i];
        proc_write <= op_tab[i];
        proc_addr  <= addr_tab[i];
        proc_wdata <= wdata_tab[i];
        @(negedge clk);
        while (proc_stall) begin
            @(negedge clk);
        end
        // completing cycle
        if (!op_tab[i] && proc_rdata != exp_tab[i]) begin
            errors++;
            $display("ERROR at %0t: read %h returned %h, expected %h", $time, addr_tab[i],
                     proc_rdata, exp_tab[i]);
        end
        if (read_count - rd0 != n_rd_tab[i] || write_count - wr0 != n_wr_tab[i]) begin
            errors++;
            $display("ERROR at %0t: %0d line reads and %0d write-backs, expected %0d and %0d",
                     $time, read_count - rd0, write_count - wr0, n_rd_tab[i], n_wr_tab[i]);
        end
        if (n_wr_tab[i] > 0 && (wb_addr_seen != wb_addr_tab[i][29:2] ||
                                wb_line_seen[wb_addr_tab[i][1:0]] != wb_word_tab[i])) begin
            errors++;
            $display("ERROR at %0t: write-back to %h word %h, expected line %h word %h", $time,
                     wb_addr_seen, wb_line_seen[wb_addr_tab[i][1:0]], wb_addr_tab[i][29:2],
                     wb_word_tab[i]);
        end
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        $display("access %0d %s %h: %s", i + 1, op_tab[i] ? "write" : "read ", addr_tab[i],
                 (errors + monitor_errors == err0) ? "ok" : "mismatch");
    endtask

    // --------------------
    // memory bus monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_read && mem_write) begin
                monitor_errors++;
                $display("ERROR at %0t: mem_read and mem_write high together", $time);
            end
            if (req_open && (mem_read || mem_write) && mem_addr != held_addr) begin
                monitor_errors++;
                $display("ERROR at %0t: mem_addr moved to %h before mem_ready", $time, mem_addr);
            end
            req_open  <= (mem_read || mem_write) && !mem_ready;
            held_addr <= mem_addr;
            if (mem_ready && mem_read) begin
                read_count <= read_count + 1;
            end
            if (mem_ready && mem_write) begin
                write_count  <= write_count + 1;
                wb_addr_seen <= mem_addr;
                wb_line_seen <= mem_wdata;
            end
        end
    end

    initial begin
        int total;
        rst_n      = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (mem_read || mem_write || proc_stall) begin
            errors++;
            $display("ERROR at %0t: memory request or stall high after reset", $time);
        end
        $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
        for (int i = 0; i < table_len; i++) begin
            run_access(i);
        end
        total = errors + monitor_errors;
        $display("%0d accesses run, %0d errors", table_len, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the cache stopped responding",
                 timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/line_memory_model.sv ====
// behavioral line memory for the cache testbench; answers each request after a random 1 to 6 cycles
`timescale 1ns/100ps
`default_nettype none

module line_memory_model (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   mem_read,
    input  wire                                   mem_write,
    input  wire [cache_pkg::line_addr_width-1:0]  mem_addr,
    input  wire cache_pkg::line_t                 mem_wdata,
    output cache_pkg::line_t                      mem_rdata,
    output logic                                  mem_ready
);

    localparam logic [31:0] seed = 32'h493c_2f78;

    cache_pkg::line_t  stored [logic [cache_pkg::line_addr_width-1:0]];  // written-back lines
    logic [31:0]       rng;
    logic [31:0]       rng_next;
    logic              busy;
    logic [2:0]        count;       // cycles left until mem_ready

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched lines follow the fill rule, word = word address ^ 5a5a_0000
    function automatic cache_pkg::line_t line_value(input logic [cache_pkg::line_addr_width-1:0] la);
        cache_pkg::line_t                l;
        logic [cache_pkg::addr_width-1:0] wa;
        logic [1:0]                      ws;
        if (stored.exists(la)) begin
            return stored[la];
        end
        for (int w = 0; w < 4; w++) begin
            ws    = w[1:0];
            wa    = {la, ws};
            l[ws] = {2'b00, wa} ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    assign rng_next = xorshift(rng);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rng       <= seed;
            busy      <= 1'b0;
            count     <= 3'd0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
        end else begin
            mem_ready <= 1'b0;
            if (mem_ready) begin
                busy <= 1'b0;           // cache drops or swaps its request now
            end else if (!busy && (mem_read || mem_write)) begin
                busy  <= 1'b1;
                rng   <= rng_next;
                count <= 3'(rng_next % 32'd6) + 3'd1;
            end else if (busy) begin
                if (count == 3'd1) begin
                    mem_ready <= 1'b1;
                    if (mem_write) begin
                        stored[mem_addr] = mem_wdata;
                    end
                    if (mem_read) begin
                        mem_rdata <= line_value(mem_addr);
                    end
                end else begin
                    count <= count - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
